// File: conv_pkg.sv
`default_nettype none

package conv_pkg;

	localparam int KERNEL_SIZE = 3;
	localparam int KERNEL_TAPS = KERNEL_SIZE * KERNEL_SIZE;

	localparam int PIXEL_WIDTH = 8;
	localparam int WEIGHT_WIDTH = 8;
	localparam int PRODUCT_WIDTH = PIXEL_WIDTH + WEIGHT_WIDTH;
	localparam int ACC_WIDTH = 20;
	localparam int POS_WIDTH = 8;

	typedef logic signed [PIXEL_WIDTH-1:0] pixel_t;
	typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;

	// nine 16-bit products need four guard bits.
	typedef logic signed [ACC_WIDTH-1:0] acc_t;

	// raster order, tap 0 is the oldest pixel at the top-left.
	typedef struct packed {
		pixel_t [KERNEL_TAPS-1:0] tap;
	} window_t;

	typedef weight_t [KERNEL_TAPS-1:0] kernel_t;

	typedef struct packed {
		logic [POS_WIDTH-1:0] row;
		logic [POS_WIDTH-1:0] col;
	} pos_t;

	typedef enum logic [1:0] {
		CONV_IDLE,
		CONV_RUN,
		CONV_DRAIN
	} conv_state_t;

endpackage

`default_nettype wire

// File: window_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module window_buffer import conv_pkg::*; #(
	parameter int IMG_SIZE = 8
) (
	input logic clk,
	input logic reset,
	input logic shift,
	input pixel_t pixel_in,
	output window_t window
);

	// enough history for the top-left pixel of the window.
	localparam int DEPTH = (KERNEL_SIZE - 1) * IMG_SIZE + KERNEL_SIZE;

	pixel_t line [DEPTH];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < DEPTH; i++)
			begin
				line[i] <= '0;
			end
		end
		else if (shift)
		begin
			line[0] <= pixel_in;
			for (int i = 1; i < DEPTH; i++)
			begin
				line[i] <= line[i-1];
			end
		end
	end

	// line[0] is the newest pixel, the bottom-right of the window.
	always_comb
	begin
		for (int r = 0; r < KERNEL_SIZE; r++)
		begin
			for (int c = 0; c < KERNEL_SIZE; c++)
			begin
				window.tap[r*KERNEL_SIZE+c] =
					line[(KERNEL_SIZE-1-r)*IMG_SIZE + (KERNEL_SIZE-1-c)];
			end
		end
	end

endmodule

`default_nettype wire

// File: position_counter.sv
`timescale 1ns/1ns
`default_nettype none

module position_counter import conv_pkg::*; #(
	parameter int IMG_SIZE = 8
) (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic advance,
	output pos_t pos,
	output logic row_end,
	output logic frame_end
);

	localparam logic [POS_WIDTH-1:0] LAST = POS_WIDTH'(IMG_SIZE - 1);

	assign row_end = (pos.col == LAST);
	assign frame_end = row_end && (pos.row == LAST);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pos <= '0;
		end
		else if (clear)
		begin
			pos <= '0;
		end
		else if (advance)
		begin
			if (frame_end)
			begin
				pos <= '0;
			end
			else if (row_end)
			begin
				pos.col <= '0;
				pos.row <= pos.row + 1'b1;
			end
			else
			begin
				pos.col <= pos.col + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: conv_control.sv
`timescale 1ns/1ns
`default_nettype none

module conv_control import conv_pkg::*; #(
	parameter int IMG_SIZE = 8
) (
	input logic clk,
	input logic reset,
	input logic frame_start,
	input logic pixel_valid,
	input pos_t pos,
	input logic frame_end,
	output logic shift,
	output logic clear,
	output logic window_valid,
	output logic busy,
	output logic frame_done
);

	localparam logic [POS_WIDTH-1:0] FIRST_FULL = POS_WIDTH'(KERNEL_SIZE - 1);

	// the last result leaves the mac on this drain count.
	localparam logic [1:0] DRAIN_LAST = 2'd2;

	conv_state_t state;
	logic [1:0] drain_count;
	logic window_complete;

	if (IMG_SIZE < KERNEL_SIZE || IMG_SIZE > 255)
	begin : g_size_check
		$error("IMG_SIZE must lie between KERNEL_SIZE and 255");
	end

	assign shift = (state == CONV_RUN) && pixel_valid;
	assign clear = (state == CONV_IDLE) && frame_start;
	assign busy = (state != CONV_IDLE);

	// no padding, so only windows wholly inside the image count.
	assign window_complete = (pos.col >= FIRST_FULL) && (pos.row >= FIRST_FULL);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= CONV_IDLE;
			drain_count <= '0;
			window_valid <= 1'b0;
			frame_done <= 1'b0;
		end
		else
		begin
			window_valid <= shift && window_complete;
			frame_done <= 1'b0;
			case (state)
				CONV_IDLE:
				begin
					if (frame_start)
					begin
						state <= CONV_RUN;
					end
				end
				CONV_RUN:
				begin
					if (shift && frame_end)
					begin
						state <= CONV_DRAIN;
						drain_count <= '0;
					end
				end
				CONV_DRAIN:
				begin
					if (drain_count == DRAIN_LAST)
					begin
						state <= CONV_IDLE;
						frame_done <= 1'b1;
					end
					else
					begin
						drain_count <= drain_count + 1'b1;
					end
				end
				default:
				begin
					state <= CONV_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: kernel_regs.sv
`timescale 1ns/1ns
`default_nettype none

module kernel_regs import conv_pkg::*; (
	input logic clk,
	input logic reset,
	input logic kernel_load,
	input weight_t weight_in,
	output kernel_t kernel
);

	// new weight enters at the top tap, the first one ends at tap 0.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			kernel <= '0;
		end
		else if (kernel_load)
		begin
			kernel <= {weight_in, kernel[KERNEL_TAPS-1:1]};
		end
	end

endmodule

`default_nettype wire

// File: window_mac.sv
`timescale 1ns/1ns
`default_nettype none

module window_mac import conv_pkg::*; (
	input logic clk,
	input logic reset,
	input logic window_valid,
	input window_t window,
	input kernel_t kernel,
	output logic result_valid,
	output acc_t result
);

	logic signed [PRODUCT_WIDTH-1:0] product [KERNEL_TAPS];
	logic product_valid;
	acc_t product_sum;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			product_valid <= 1'b0;
			result_valid <= 1'b0;
		end
		else
		begin
			product_valid <= window_valid;
			result_valid <= product_valid;
		end
	end

	// stage one, one signed product per tap.
	always_ff @(posedge clk)
	begin
		if (window_valid)
		begin
			for (int i = 0; i < KERNEL_TAPS; i++)
			begin
				product[i] <= $signed(window.tap[i]) * $signed(kernel[i]);
			end
		end
	end

	always_comb
	begin
		product_sum = '0;
		for (int i = 0; i < KERNEL_TAPS; i++)
		begin
			product_sum = product_sum + acc_t'(product[i]);
		end
	end

	// stage two.
	always_ff @(posedge clk)
	begin
		if (product_valid)
		begin
			result <= product_sum;
		end
	end

endmodule

`default_nettype wire

// File: conv_layer.sv
`timescale 1ns/1ns
`default_nettype none

module conv_layer import conv_pkg::*; #(
	parameter int IMG_SIZE = 8
) (
	input logic clk,
	input logic reset,
	input logic kernel_load,
	input weight_t weight_in,
	input logic frame_start,
	input logic pixel_valid,
	input pixel_t pixel_in,
	output logic busy,
	output logic result_valid,
	output acc_t result,
	output logic frame_done
);

	logic shift;
	logic clear;
	logic window_valid;
	logic frame_end;
	pos_t pos;
	window_t window;
	kernel_t kernel;

	window_buffer #(
		.IMG_SIZE(IMG_SIZE)
	) window_buffer_inst (
		.clk(clk),
		.reset(reset),
		.shift(shift),
		.pixel_in(pixel_in),
		.window(window)
	);

	// row_end is only needed inside the counter.
	position_counter #(
		.IMG_SIZE(IMG_SIZE)
	) position_counter_inst (
		.clk(clk),
		.reset(reset),
		.clear(clear),
		.advance(shift),
		.pos(pos),
		.row_end(),
		.frame_end(frame_end)
	);

	conv_control #(
		.IMG_SIZE(IMG_SIZE)
	) conv_control_inst (
		.clk(clk),
		.reset(reset),
		.frame_start(frame_start),
		.pixel_valid(pixel_valid),
		.pos(pos),
		.frame_end(frame_end),
		.shift(shift),
		.clear(clear),
		.window_valid(window_valid),
		.busy(busy),
		.frame_done(frame_done)
	);

	kernel_regs kernel_regs_inst (
		.clk(clk),
		.reset(reset),
		.kernel_load(kernel_load),
		.weight_in(weight_in),
		.kernel(kernel)
	);

	window_mac window_mac_inst (
		.clk(clk),
		.reset(reset),
		.window_valid(window_valid),
		.window(window),
		.kernel(kernel),
		.result_valid(result_valid),
		.result(result)
	);

endmodule

`default_nettype wire

// File: conv_layer_properties.sv
`timescale 1ns/1ns
`default_nettype none

module conv_layer_properties import conv_pkg::*; (
	input logic clk,
	input logic reset,
	input logic frame_start,
	input logic shift,
	input logic busy,
	input logic result_valid,
	input logic frame_done,
	input pos_t pos
);

	localparam logic [POS_WIDTH-1:0] FIRST_FULL = POS_WIDTH'(KERNEL_SIZE - 1);

	logic accepted;

	assign accepted = shift && (pos.col >= FIRST_FULL) && (pos.row >= FIRST_FULL);

	// a result set two edges after acceptance is sampled on the third edge.
	result_timing: assert property (@(posedge clk) disable iff (reset)
		result_valid == $past(accepted, 3))
		else $error("result_valid not two cycles after an accepted complete window");

	done_after_result: assert property (@(posedge clk) disable iff (reset)
		frame_done |-> $past(result_valid))
		else $error("frame_done not one cycle after the last result");

	done_ends_busy: assert property (@(posedge clk) disable iff (reset)
		frame_done |-> ($past(busy) && !busy))
		else $error("frame_done outside a busy frame");

	busy_falls_with_done: assert property (@(posedge clk) disable iff (reset)
		$fell(busy) |-> frame_done)
		else $error("busy fell without frame_done");

	start_raises_busy: assert property (@(posedge clk) disable iff (reset)
		(frame_start && !busy) |=> busy)
		else $error("frame_start in idle did not raise busy");

	result_while_busy: assert property (@(posedge clk) disable iff (reset)
		result_valid |-> busy)
		else $error("result_valid while idle");

endmodule

bind conv_layer conv_layer_properties conv_layer_properties_inst (
	.clk(clk),
	.reset(reset),
	.frame_start(frame_start),
	.shift(shift),
	.busy(busy),
	.result_valid(result_valid),
	.frame_done(frame_done),
	.pos(pos)
);

`default_nettype wire

// File: tb_conv_layer.sv
`timescale 1ns/1ns
`default_nettype none

module tb_conv_layer import conv_pkg::*; ();

	localparam int IMG_SIZE = 8;
	localparam int OUT_SIZE = IMG_SIZE - KERNEL_SIZE + 1;
	localparam int RESULTS_PER_FRAME = OUT_SIZE * OUT_SIZE;
	localparam int FRAME_TIMEOUT = 200;

	logic clk;
	logic reset;
	logic kernel_load;
	weight_t weight_in;
	logic frame_start;
	logic pixel_valid;
	pixel_t pixel_in;
	logic busy;
	logic result_valid;
	acc_t result;
	logic frame_done;

	logic [31:0] lfsr_state;
	pixel_t frame_pix [IMG_SIZE*IMG_SIZE];
	weight_t weights [KERNEL_TAPS];
	acc_t expected [$];
	int results_seen;
	int value_errors;
	int other_errors;
	logic last_result_valid;

	conv_layer #(
		.IMG_SIZE(IMG_SIZE)
	) conv_layer_inst (
		.clk(clk),
		.reset(reset),
		.kernel_load(kernel_load),
		.weight_in(weight_in),
		.frame_start(frame_start),
		.pixel_valid(pixel_valid),
		.pixel_in(pixel_in),
		.busy(busy),
		.result_valid(result_valid),
		.result(result),
		.frame_done(frame_done)
	);

	always #5 clk = ~clk;

	// taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// window with its bottom-right pixel at (row, col), tap 0 at the top-left.
	function automatic acc_t window_sum(input int row, input int col);
		int sum;
		sum = 0;
		for (int r = 0; r < KERNEL_SIZE; r++)
		begin
			for (int c = 0; c < KERNEL_SIZE; c++)
			begin
				sum += int'(frame_pix[(row-KERNEL_SIZE+1+r)*IMG_SIZE + col-KERNEL_SIZE+1+c])
					* int'(weights[r*KERNEL_SIZE+c]);
			end
		end
		return acc_t'(sum);
	endfunction

	task automatic load_kernel();
		assert (!busy) else
		begin
			other_errors++;
			$display("kernel load attempted while busy at %0t", $time);
		end
		for (int i = 0; i < KERNEL_TAPS; i++)
		begin
			weights[i] = weight_t'(random_bits(8));
			kernel_load = 1'b1;
			weight_in = weights[i];
			@(negedge clk);
		end
		kernel_load = 1'b0;
		weight_in = '0;
	endtask

	task automatic run_frame(input bit with_gaps);
		int gap;
		int waited;
		for (int i = 0; i < IMG_SIZE * IMG_SIZE; i++)
		begin
			frame_pix[i] = pixel_t'(random_bits(8));
		end
		expected.delete();
		for (int row = KERNEL_SIZE - 1; row < IMG_SIZE; row++)
		begin
			for (int col = KERNEL_SIZE - 1; col < IMG_SIZE; col++)
			begin
				expected.push_back(window_sum(row, col));
			end
		end
		results_seen = 0;
		frame_start = 1'b1;
		@(negedge clk);
		frame_start = 1'b0;
		for (int i = 0; i < IMG_SIZE * IMG_SIZE; i++)
		begin
			gap = with_gaps ? int'(random_bits(2)) : 0;
			repeat (gap)
			begin
				pixel_valid = 1'b0;
				@(negedge clk);
			end
			pixel_valid = 1'b1;
			pixel_in = frame_pix[i];
			@(negedge clk);
		end
		pixel_valid = 1'b0;
		pixel_in = '0;
		waited = 0;
		while (!frame_done && waited < FRAME_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!frame_done)
		begin
			other_errors++;
			$display("timed out waiting for frame_done at %0t", $time);
		end
		assert (results_seen == RESULTS_PER_FRAME && expected.size() == 0) else
		begin
			other_errors++;
			$display("frame gave %0d results instead of %0d", results_seen, RESULTS_PER_FRAME);
		end
		@(negedge clk);
	endtask

	// strobes while idle must be ignored.
	task automatic strobe_idle_pixels();
		int seen_before;
		seen_before = results_seen;
		for (int i = 0; i < 6; i++)
		begin
			pixel_valid = 1'b1;
			pixel_in = pixel_t'(random_bits(8));
			@(negedge clk);
		end
		pixel_valid = 1'b0;
		repeat (5) @(negedge clk);
		assert (results_seen == seen_before && !busy) else
		begin
			other_errors++;
			$display("idle pixel strobes produced a result or started a frame");
		end
	endtask

	always @(negedge clk)
	begin
		acc_t want;
		if (!reset)
		begin
			if (result_valid)
			begin
				if (expected.size() == 0)
				begin
					other_errors++;
					$display("unexpected result at %0t with no window outstanding", $time);
				end
				else
				begin
					want = expected.pop_front();
					assert (result == want) else
					begin
						value_errors++;
						$display("[FAIL] %0t: result %0d, expected %0d", $time, result, want);
					end
				end
				results_seen++;
			end
			if (frame_done)
			begin
				assert (last_result_valid && !busy) else
				begin
					other_errors++;
					$display("frame_done did not follow the last result with busy low");
				end
			end
			last_result_valid = result_valid;
		end
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		kernel_load = 1'b0;
		weight_in = '0;
		frame_start = 1'b0;
		pixel_valid = 1'b0;
		pixel_in = '0;
		lfsr_state = 32'h19b;
		results_seen = 0;
		value_errors = 0;
		other_errors = 0;
		last_result_valid = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		assert (!busy && !result_valid && !frame_done) else
		begin
			other_errors++;
			$display("outputs not idle after reset");
		end
		load_kernel();
		run_frame(1'b0);
		strobe_idle_pixels();
		load_kernel();
		run_frame(1'b1);
		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: conv_layer.f
conv_pkg.sv
window_buffer.sv
position_counter.sv
conv_control.sv
kernel_regs.sv
window_mac.sv
conv_layer.sv
conv_layer_properties.sv
tb_conv_layer.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the conv_layer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f conv_layer.f \
	--top-module tb_conv_layer -o tb_conv_layer_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/tb_conv_layer_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
